// File: design/channel_sched.sv
`timescale 1ns/1ps
`include "csa_params.svh"

module channel_sched (
	input  logic                         clk,
	input  logic                         rst,
	input  csa_pkg::ts_word_t            frm_word,
	input  logic                         frm_valid,
	output csa_pkg::cont_t               cont,
	output csa_pkg::ts_word_t            ts_dout,
	output logic [`CSA_CHANNEL_NUM-1:0]  ts_dout_en
);

	import csa_pkg::*;

	chan_t chan;
	logic  frm_valid_q;
	logic  frm_end;

	////////////////////
	// rotation
	////////////////////

	// falling edge of valid closes a frame
	assign frm_end = frm_valid_q && !frm_valid;

	always_ff @(posedge clk)
	begin
		if (rst)
			frm_valid_q <= 1'b0;
		else
			frm_valid_q <= frm_valid;
	end

	// wrap of the channel index bumps continuity
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			chan <= '0;
			cont <= '0;
		end
		else if (frm_end)
		begin
			if (chan == chan_t'(`CSA_CHANNEL_NUM - 1))
			begin
				chan <= '0;
				cont <= cont + 1'b1;
			end
			else
			begin
				chan <= chan + 1'b1;
			end
		end
	end

	////////////////////
	// output stage
	////////////////////

	always_ff @(posedge clk)
	begin
		ts_dout <= frm_word;
	end

	// only the current channel sees the frame
	always_ff @(posedge clk)
	begin
		if (rst)
			ts_dout_en <= '0;
		else if (frm_valid)
			ts_dout_en <= `CSA_CHANNEL_NUM'(1) << chan;
		else
			ts_dout_en <= '0;
	end

	a_onehot_en : assert property (@(posedge clk) disable iff (rst) $onehot0(ts_dout_en))
		else $error("more than one channel enabled");

endmodule

// File: design/csa_params.svh
`ifndef CSA_PARAMS_SVH
`define CSA_PARAMS_SVH

// pid field in word 0, also the table address
`define CSA_PID_W 12
// per-pid tables, one entry per address
`define CSA_TABLE_DEPTH (1 << `CSA_PID_W)

// output side
`define CSA_CHANNEL_NUM 32
`define CSA_CONT_W 4
`define CSA_TS_W 32

// key material
`define CSA_CW_W 64
`define CSA_CW_BYTES 8

// header words ahead of each packet
`define CSA_HDR_WORDS 4
// bit positions inside header word 1
`define CSA_HDR_FLAG_BIT 2
`define CSA_HDR_PARITY_BIT 0

// configuration byte streams
`define CSA_CFG_W 8

`endif

// File: design/csa_pkg.sv
`include "csa_params.svh"

package csa_pkg;

	////////////////////
	// scalar types
	////////////////////

	// pid, also the table address
	typedef logic [`CSA_PID_W-1:0] pid_t;

	// one configuration byte
	typedef logic [`CSA_CFG_W-1:0] cfg_byte_t;

	// output channel index
	typedef logic [$clog2(`CSA_CHANNEL_NUM)-1:0] chan_t;

	// continuity count, bumps once per channel rotation
	typedef logic [`CSA_CONT_W-1:0] cont_t;

	////////////////////
	// packed records
	////////////////////

	// one control-word table entry
	typedef struct packed {
		logic parity;
		logic [`CSA_CW_W-1:0] cw;
	} cw_entry_t;

	// output word, start marks header word 0 of a frame
	typedef struct packed {
		logic start;
		logic [`CSA_TS_W-1:0] data;
	} ts_word_t;

endpackage

// File: design/csa_ts_top.sv
`timescale 1ns/1ps
`include "csa_params.svh"

module csa_ts_top (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [`CSA_TS_W-1:0]         ts_din,
	input  logic                         ts_din_en,
	input  csa_pkg::cfg_byte_t           pid_cfg_din,
	input  logic                         pid_cfg_din_en,
	input  csa_pkg::cfg_byte_t           cw_cfg_din,
	input  logic                         cw_cfg_din_en,
	output csa_pkg::ts_word_t            ts_dout,
	output logic [`CSA_CHANNEL_NUM-1:0]  ts_dout_en
);

	import csa_pkg::*;

	// config write ports
	pid_t      pid_wr_addr;
	logic      pid_wr_flag;
	logic      pid_wr;
	pid_t      cw_wr_addr;
	cw_entry_t cw_wr_entry;
	logic      cw_wr;
	// lookup
	pid_t      pid_addr;
	logic      pid_flag;
	cw_entry_t cw_entry;
	// inserter to scheduler
	ts_word_t  frm_word;
	logic      frm_valid;
	cont_t     cont;

	pid_cfg_parser u_pid_cfg (
		.clk        (clk),
		.rst        (rst),
		.cfg_din    (pid_cfg_din),
		.cfg_din_en (pid_cfg_din_en),
		.wr_addr    (pid_wr_addr),
		.wr_flag    (pid_wr_flag),
		.wr         (pid_wr)
	);

	cw_cfg_parser u_cw_cfg (
		.clk        (clk),
		.rst        (rst),
		.cfg_din    (cw_cfg_din),
		.cfg_din_en (cw_cfg_din_en),
		.wr_addr    (cw_wr_addr),
		.wr_entry   (cw_wr_entry),
		.wr         (cw_wr)
	);

	// scramble flag per pid
	key_table #(.entry_t(logic)) u_pid_table (
		.clk      (clk),
		.wr_addr  (pid_wr_addr),
		.wr_entry (pid_wr_flag),
		.wr       (pid_wr),
		.rd_addr  (pid_addr),
		.rd_entry (pid_flag)
	);

	// control word and parity per pid
	key_table #(.entry_t(cw_entry_t)) u_cw_table (
		.clk      (clk),
		.wr_addr  (cw_wr_addr),
		.wr_entry (cw_wr_entry),
		.wr       (cw_wr),
		.rd_addr  (pid_addr),
		.rd_entry (cw_entry)
	);

	ts_header_inserter u_inserter (
		.clk       (clk),
		.rst       (rst),
		.ts_din    (ts_din),
		.ts_din_en (ts_din_en),
		.pid_addr  (pid_addr),
		.pid_flag  (pid_flag),
		.cw_entry  (cw_entry),
		.cont      (cont),
		.frm_word  (frm_word),
		.frm_valid (frm_valid)
	);

	channel_sched u_sched (
		.clk        (clk),
		.rst        (rst),
		.frm_word   (frm_word),
		.frm_valid  (frm_valid),
		.cont       (cont),
		.ts_dout    (ts_dout),
		.ts_dout_en (ts_dout_en)
	);

endmodule

// File: design/cw_cfg_parser.sv
`timescale 1ns/1ps
`include "csa_params.svh"

module cw_cfg_parser (
	input  logic                clk,
	input  logic                rst,
	input  csa_pkg::cfg_byte_t  cfg_din,
	input  logic                cfg_din_en,
	output csa_pkg::pid_t       wr_addr,
	output csa_pkg::cw_entry_t  wr_entry,
	output logic                wr
);

	// parity byte plus control-word bytes
	logic [3:0] key_idx;
	logic       key_done;
	// low byte of an address pair is next
	logic       pair_lo;

	////////////////////
	// frame sequencing
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst || !cfg_din_en)
		begin
			key_idx  <= '0;
			key_done <= 1'b0;
			pair_lo  <= 1'b0;
		end
		else if (!key_done)
		begin
			key_idx <= key_idx + 1'b1;
			if (key_idx == 4'(`CSA_CW_BYTES))
				key_done <= 1'b1;
		end
		else
		begin
			pair_lo <= !pair_lo;
		end
	end

	////////////////////
	// key and address
	////////////////////

	// byte 0 parity, then cw shifted in msb first
	always_ff @(posedge clk)
	begin
		if (cfg_din_en && !key_done)
		begin
			if (key_idx == 4'd0)
				wr_entry.parity <= cfg_din[0];
			else
				wr_entry.cw <= {wr_entry.cw[`CSA_CW_W-`CSA_CFG_W-1:0], cfg_din};
		end
	end

	// same key may go to any number of pids
	always_ff @(posedge clk)
	begin
		if (cfg_din_en && key_done)
		begin
			if (!pair_lo)
				wr_addr[`CSA_PID_W-1:8] <= cfg_din[`CSA_PID_W-9:0];
			else
				wr_addr[7:0] <= cfg_din;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			wr <= 1'b0;
		else
			wr <= cfg_din_en && key_done && pair_lo;
	end

	// first pair completes 11 bytes into the frame at the earliest
	a_key_first : assert property (@(posedge clk) disable iff (rst)
		$rose(cfg_din_en) |-> !wr [*(`CSA_CW_BYTES + 3)])
		else $error("cw table written before the key bytes arrived");

endmodule

// File: design/key_table.sv
`timescale 1ns/1ps
`include "csa_params.svh"

module key_table #(
	parameter type entry_t = logic
) (
	input  logic          clk,
	// config side
	input  csa_pkg::pid_t wr_addr,
	input  entry_t        wr_entry,
	input  logic          wr,
	// lookup side
	input  csa_pkg::pid_t rd_addr,
	output entry_t        rd_entry
);

	localparam int DEPTH = `CSA_TABLE_DEPTH;

	// one entry per pid, never cleared
	entry_t mem [DEPTH];

	// write port
	always_ff @(posedge clk)
	begin
		if (wr)
		begin
			mem[wr_addr] <= wr_entry;
		end
	end

	// registered read, old data on a same-address collision
	always_ff @(posedge clk)
	begin
		rd_entry <= mem[rd_addr];
	end

endmodule

// File: design/pid_cfg_parser.sv
`timescale 1ns/1ps
`include "csa_params.svh"

module pid_cfg_parser (
	input  logic               clk,
	input  logic               rst,
	input  csa_pkg::cfg_byte_t cfg_din,
	input  logic               cfg_din_en,
	output csa_pkg::pid_t      wr_addr,
	output logic               wr_flag,
	output logic               wr
);

	// position inside the 3-byte group
	logic [1:0] byte_cnt;

	// group counter, restarts with every frame
	always_ff @(posedge clk)
	begin
		if (rst || !cfg_din_en)
			byte_cnt <= '0;
		else if (byte_cnt == 2'd2)
			byte_cnt <= '0;
		else
			byte_cnt <= byte_cnt + 1'b1;
	end

	// address high nibble, then low byte, then flag
	always_ff @(posedge clk)
	begin
		if (cfg_din_en)
		begin
			case (byte_cnt)
				2'd0: wr_addr[`CSA_PID_W-1:8] <= cfg_din[`CSA_PID_W-9:0];
				2'd1: wr_addr[7:0] <= cfg_din;
				default: wr_flag <= cfg_din[0];
			endcase
		end
	end

	// strobe on the cycle after the flag byte
	always_ff @(posedge clk)
	begin
		if (rst)
			wr <= 1'b0;
		else
			wr <= cfg_din_en && (byte_cnt == 2'd2);
	end

	// groups are three bytes, so writes never run back to back
	a_wr_spaced : assert property (@(posedge clk) disable iff (rst) wr |=> !wr)
		else $error("pid table write strobe held for two cycles");

endmodule

// File: design/ts_header_inserter.sv
`timescale 1ns/1ps
`include "csa_params.svh"

module ts_header_inserter (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`CSA_TS_W-1:0]   ts_din,
	input  logic                   ts_din_en,
	// table lookup
	output csa_pkg::pid_t          pid_addr,
	input  logic                   pid_flag,
	input  csa_pkg::cw_entry_t     cw_entry,
	// to the scheduler
	input  csa_pkg::cont_t         cont,
	output csa_pkg::ts_word_t      frm_word,
	output logic                   frm_valid
);

	localparam int HDR = `CSA_HDR_WORDS;

	logic [7:0]          word_cnt;
	logic                sop;
	// input register ahead of the delay line
	logic [`CSA_TS_W-1:0] din_q;
	logic                din_en_q;
	logic [`CSA_TS_W-1:0] dly_data [HDR];
	logic [HDR-1:0]      dly_en;
	// header phase
	logic                hdr_act;
	logic [1:0]          hdr_idx;
	logic [`CSA_CW_W-1:0] cw_hold;

	////////////////////
	// packet front
	////////////////////

	assign sop = ts_din_en && (word_cnt == 8'd0);

	// saturates on long packets so word 0 is seen once
	always_ff @(posedge clk)
	begin
		if (rst || !ts_din_en)
			word_cnt <= '0;
		else if (word_cnt != 8'hff)
			word_cnt <= word_cnt + 1'b1;
	end

	// pid taken from word 0, held for the whole frame
	always_ff @(posedge clk)
	begin
		if (sop)
			pid_addr <= ts_din[`CSA_PID_W-1:0];
	end

	// packet waits here while the header goes out
	always_ff @(posedge clk)
	begin
		din_q       <= ts_din;
		dly_data[0] <= din_q;
		for (int i = 1; i < HDR; i++)
			dly_data[i] <= dly_data[i-1];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			din_en_q <= 1'b0;
			dly_en   <= '0;
		end
		else
		begin
			din_en_q <= ts_din_en;
			dly_en   <= {dly_en[HDR-2:0], din_en_q};
		end
	end

	////////////////////
	// header phase
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			hdr_act <= 1'b0;
			hdr_idx <= '0;
		end
		else if (sop)
		begin
			hdr_act <= 1'b1;
			hdr_idx <= '0;
		end
		else if (hdr_act)
		begin
			hdr_idx <= hdr_idx + 1'b1;
			if (hdr_idx == 2'(HDR - 1))
				hdr_act <= 1'b0;
		end
	end

	// lookup data lands during header word 1
	always_ff @(posedge clk)
	begin
		if (hdr_act && hdr_idx == 2'd1)
			cw_hold <= cw_entry.cw;
	end

	// header words, then the delayed packet
	always_ff @(posedge clk)
	begin
		frm_word.start <= 1'b0;
		frm_word.data  <= dly_data[HDR-1];
		if (hdr_act)
		begin
			case (hdr_idx)
				2'd0:
				begin
					frm_word.start <= 1'b1;
					frm_word.data  <= {{(`CSA_TS_W-`CSA_CONT_W){1'b0}}, cont};
				end
				2'd1: frm_word.data <= {{(`CSA_TS_W-3){1'b0}}, pid_flag, 1'b0, cw_entry.parity};
				2'd2: frm_word.data <= cw_hold[`CSA_CW_W-1:`CSA_TS_W];
				default: frm_word.data <= cw_hold[`CSA_TS_W-1:0];
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			frm_valid <= 1'b0;
		else
			frm_valid <= hdr_act || dly_en[HDR-1];
	end

	// input spacing must leave room for the header
	a_no_overlap : assert property (@(posedge clk) disable iff (rst) sop |-> !hdr_act)
		else $error("packet started inside a header phase");

endmodule

// File: dv/csa_checker.sv
`timescale 1ns/1ps
`include "csa_params.svh"

module csa_checker (
	input  logic                         clk,
	input  logic                         rst,
	input  int                           cyc,
	input  csa_pkg::ts_word_t            ts_dout,
	input  logic [`CSA_CHANNEL_NUM-1:0]  ts_dout_en,
	output int                           value_errs,
	output int                           other_errs
);

	import csa_pkg::*;

	// expected output, one entry per frame word
	ts_word_t                    exp_word [$];
	logic [`CSA_CHANNEL_NUM-1:0] exp_en [$];
	string                       exp_name [$];
	// cycle at which each header word 0 is due
	int                          exp_start [$];

	task automatic push_word(input string name, input ts_word_t word,
		input logic [`CSA_CHANNEL_NUM-1:0] en);
		exp_word.push_back(word);
		exp_en.push_back(en);
		exp_name.push_back(name);
	endtask

	task automatic push_start(input int at_cyc);
		exp_start.push_back(at_cyc);
	endtask

	function automatic int pending_words();
		return exp_word.size();
	endfunction

	////////////////////
	// compare
	////////////////////

	// outputs settle after the rising edge, looked at on the falling one
	always @(negedge clk)
	begin
		ts_word_t                    w;
		logic [`CSA_CHANNEL_NUM-1:0] en;
		string                       name;
		int                          due;
		if (rst)
		begin
			value_errs = 0;
			other_errs = 0;
		end
		else if (ts_dout_en !== '0)
		begin
			if (exp_word.size() == 0)
			begin
				$display("output word %h on channel mask %h with no frame expected",
					ts_dout, ts_dout_en);
				other_errs++;
			end
			else
			begin
				w    = exp_word.pop_front();
				en   = exp_en.pop_front();
				name = exp_name.pop_front();
				if (ts_dout !== w)
				begin
					$display("error: test %s word expected %h actual %h", name, w, ts_dout);
					value_errs++;
				end
				if (ts_dout_en !== en)
				begin
					$display("error: test %s enable expected %h actual %h",
						name, en, ts_dout_en);
					value_errs++;
				end
				// frame start latency
				if (ts_dout.start)
				begin
					if (exp_start.size() == 0)
					begin
						$display("frame start seen with no start time expected");
						other_errs++;
					end
					else
					begin
						due = exp_start.pop_front();
						if (cyc != due)
						begin
							$display("error: test %s start cycle expected %0d actual %0d",
								name, due, cyc);
							value_errs++;
						end
					end
				end
			end
		end
	end

endmodule

// File: dv/tb_csa_ts.sv
`timescale 1ns/1ps
`include "csa_params.svh"

module tb_csa_ts;

	import csa_pkg::*;

	localparam int NROWS     = 6;
	localparam int MAX_PIDS  = 3;
	localparam int PKT_WORDS = 47;
	localparam int PKT_GAP   = 6;

	logic                        clk;
	logic                        rst;
	logic [`CSA_TS_W-1:0]        ts_din;
	logic                        ts_din_en;
	cfg_byte_t                   pid_cfg_din;
	logic                        pid_cfg_din_en;
	cfg_byte_t                   cw_cfg_din;
	logic                        cw_cfg_din_en;
	ts_word_t                    ts_dout;
	logic [`CSA_CHANNEL_NUM-1:0] ts_dout_en;

	int cyc = 0;
	int limit;
	int value_errs;
	int other_errs;

	////////////////////
	// stimulus table
	////////////////////

	string       row_name [NROWS] = '{"reset_idle", "scrambled_rotation", "clear_flag",
		"shared_key", "key_rewrite", "other_pids_kept"};
	pid_t        row_pid [NROWS][MAX_PIDS] = '{'{12'h000, 12'h000, 12'h000},
		'{12'h123, 12'h000, 12'h000}, '{12'h123, 12'h0a5, 12'h000},
		'{12'h200, 12'h201, 12'hfff}, '{12'h123, 12'h000, 12'h000},
		'{12'h0a5, 12'h201, 12'h000}};
	int          row_npid [NROWS] = '{1, 1, 2, 3, 1, 2};
	// configure before the packets
	bit          row_cfg [NROWS] = '{0, 1, 1, 1, 1, 0};
	bit          row_flag [NROWS] = '{0, 1, 0, 1, 1, 0};
	bit          row_parity [NROWS] = '{0, 1, 0, 0, 0, 0};
	logic [63:0] row_cw [NROWS] = '{64'h0, 64'h0123_4567_89ab_cdef,
		64'hfedc_ba98_7654_3210, 64'h5a5a_c3c3_0ff0_9669, 64'h1357_9bdf_2468_ace0, 64'h0};
	int          row_pkts [NROWS] = '{0, 34, 2, 3, 2, 2};

	// what the tables should hold
	bit        flag_model [`CSA_TABLE_DEPTH];
	cw_entry_t cw_model [`CSA_TABLE_DEPTH];
	// running output channel and continuity
	int        chan_cnt;
	cont_t     cont_cnt;

	csa_ts_top DUT (
		.clk            (clk),
		.rst            (rst),
		.ts_din         (ts_din),
		.ts_din_en      (ts_din_en),
		.pid_cfg_din    (pid_cfg_din),
		.pid_cfg_din_en (pid_cfg_din_en),
		.cw_cfg_din     (cw_cfg_din),
		.cw_cfg_din_en  (cw_cfg_din_en),
		.ts_dout        (ts_dout),
		.ts_dout_en     (ts_dout_en)
	);

	csa_checker u_checker (
		.clk        (clk),
		.rst        (rst),
		.cyc        (cyc),
		.ts_dout    (ts_dout),
		.ts_dout_en (ts_dout_en),
		.value_errs (value_errs),
		.other_errs (other_errs)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic report_and_finish(input bit timed_out);
		$display("closing: %0d value errors, %0d other errors", value_errs, other_errs);
		if (!timed_out && value_errs == 0 && other_errs == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	endtask

	// cycle count, also the run limit
	always @(posedge clk)
	begin
		cyc <= cyc + 1;
		if (cyc > limit)
		begin
			$display("timeout after %0d cycles with %0d expected output words missing",
				cyc, u_checker.pending_words());
			report_and_finish(1'b1);
		end
	end

	////////////////////
	// config drivers
	////////////////////

	// groups of address high, address low, flag
	task automatic send_pid_cfg(input int r);
		pid_t pid;
		for (int p = 0; p < row_npid[r]; p++)
		begin
			pid = row_pid[r][p];
			@(negedge clk);
			pid_cfg_din_en = 1'b1;
			pid_cfg_din    = {4'b0, pid[11:8]};
			@(negedge clk);
			pid_cfg_din    = pid[7:0];
			@(negedge clk);
			pid_cfg_din    = {7'b0, row_flag[r]};
			flag_model[pid] = row_flag[r];
		end
		@(negedge clk);
		pid_cfg_din_en = 1'b0;
		pid_cfg_din    = '0;
	endtask

	// parity, key msb first, then address pairs
	task automatic send_cw_cfg(input int r);
		pid_t pid;
		@(negedge clk);
		cw_cfg_din_en = 1'b1;
		cw_cfg_din    = {7'b0, row_parity[r]};
		for (int b = 7; b >= 0; b--)
		begin
			@(negedge clk);
			cw_cfg_din = row_cw[r][b*8 +: 8];
		end
		for (int p = 0; p < row_npid[r]; p++)
		begin
			pid = row_pid[r][p];
			@(negedge clk);
			cw_cfg_din = {4'b0, pid[11:8]};
			@(negedge clk);
			cw_cfg_din = pid[7:0];
			cw_model[pid].parity = row_parity[r];
			cw_model[pid].cw     = row_cw[r];
		end
		@(negedge clk);
		cw_cfg_din_en = 1'b0;
		cw_cfg_din    = '0;
	endtask

	////////////////////
	// packets
	////////////////////

	task automatic send_packet(input string name, input pid_t pid);
		logic [`CSA_TS_W-1:0]        words [PKT_WORDS];
		logic [`CSA_CHANNEL_NUM-1:0] en;
		ts_word_t                    w;
		cw_entry_t                   key;
		key = cw_model[pid];
		en  = '0;
		en[chan_cnt] = 1'b1;
		for (int i = 0; i < PKT_WORDS; i++)
			words[i] = $urandom();
		words[0][`CSA_PID_W-1:0] = pid;
		// header as the output should carry it
		w.start = 1'b1;
		w.data  = {{(`CSA_TS_W-`CSA_CONT_W){1'b0}}, cont_cnt};
		u_checker.push_word(name, w, en);
		w.start = 1'b0;
		w.data  = {{(`CSA_TS_W-3){1'b0}}, flag_model[pid], 1'b0, key.parity};
		u_checker.push_word(name, w, en);
		w.data  = key.cw[63:32];
		u_checker.push_word(name, w, en);
		w.data  = key.cw[31:0];
		u_checker.push_word(name, w, en);
		// payload passes through as is
		for (int i = 0; i < PKT_WORDS; i++)
		begin
			w.data = words[i];
			u_checker.push_word(name, w, en);
		end
		@(negedge clk);
		u_checker.push_start(cyc + 3);
		ts_din_en = 1'b1;
		ts_din    = words[0];
		for (int i = 1; i < PKT_WORDS; i++)
		begin
			@(negedge clk);
			ts_din = words[i];
		end
		@(negedge clk);
		ts_din_en = 1'b0;
		ts_din    = '0;
		repeat (PKT_GAP - 1) @(negedge clk);
		// next frame moves on one channel
		chan_cnt++;
		if (chan_cnt == `CSA_CHANNEL_NUM)
		begin
			chan_cnt = 0;
			cont_cnt = cont_cnt + 1'b1;
		end
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial
	begin
		void'($urandom(45431));
		rst            = 1'b1;
		ts_din         = '0;
		ts_din_en      = 1'b0;
		pid_cfg_din    = '0;
		pid_cfg_din_en = 1'b0;
		cw_cfg_din     = '0;
		cw_cfg_din_en  = 1'b0;
		chan_cnt       = 0;
		cont_cnt       = '0;
		limit          = 0;
		for (int r = 0; r < NROWS; r++)
			limit += row_pkts[r] * 57 + 200;

		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		for (int r = 0; r < NROWS; r++)
		begin
			if (row_cfg[r])
			begin
				send_pid_cfg(r);
				send_cw_cfg(r);
			end
			// tables settle before the first lookup
			repeat (4) @(negedge clk);
			for (int p = 0; p < row_pkts[r]; p++)
				send_packet(row_name[r], row_pid[r][p % row_npid[r]]);
		end

		// drain the pipeline, then look for stray output
		while (u_checker.pending_words() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
		report_and_finish(1'b0);
	end

endmodule

// File: list.f
+incdir+design
design/csa_pkg.sv
design/key_table.sv
design/pid_cfg_parser.sv
design/cw_cfg_parser.sv
design/ts_header_inserter.sv
design/channel_sched.sv
design/csa_ts_top.sv
dv/csa_checker.sv
dv/tb_csa_ts.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with verilator, result taken from sim.log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f list.f \
	--top-module tb_csa_ts

./obj_dir/Vtb_csa_ts > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
